/* common/pipe_macros.svh */
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// data path width of the core.
`define XLEN 32

// register file address width.
`define REG_AW 5

// word address width of the shared memory bus.
`define MEM_AW 8

// cycles a MUL occupies the execute stage.
`define MUL_CYCLES 4

`endif

/* common/pipe_pkg.sv */
`include "pipe_macros.svh"

package pipe_pkg;

	typedef enum logic [1:0] {
		STALL_NEXT = 2'b00,
		STALL_KEEP = 2'b01,
		STALL_ZERO = 2'b10
	} stall_e;

	typedef enum logic [2:0] {
		OP_NOP,
		OP_ADDI,
		OP_ADD,
		OP_MUL,
		OP_LW,
		OP_SW,
		OP_BEQ
	} op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_AW-1:0] rd;
		logic [6:0] opcode;
	} instr_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [`REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_AW-1:0] rd;
		logic [6:0] opcode;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		stall_e pc;
		stall_e if_id;
		stall_e id_ex;
		stall_e ex_me;
		stall_e me_wb;
	} pipe_stall_t;

	typedef struct packed {
		logic valid;
		op_e op;
		logic [`REG_AW-1:0] rd;
		logic rs1_en;
		logic [`REG_AW-1:0] rs1;
		logic rs2_en;
		logic [`REG_AW-1:0] rs2;
		logic [`XLEN-1:0] opa;
		logic [`XLEN-1:0] opb;
		logic [`XLEN-1:0] store_data;
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] pc;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		op_e op;
		logic [`REG_AW-1:0] rd;
		logic we;
		logic [`XLEN-1:0] result;
		logic [`XLEN-1:0] store_data;
	} ex_me_t;

	typedef struct packed {
		logic valid;
		logic we;
		logic [`MEM_AW-1:0] addr;
		logic [`XLEN-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] data;
	} retire_t;

	typedef struct packed {
		logic load_in_ex;
		logic [`REG_AW-1:0] rd_ex;
		logic [`REG_AW-1:0] rd_me;
		logic transfer;
		logic [`XLEN-1:0] target;
		logic mul_req;
	} ex_hazard_t;

endpackage

/* hdl/hazard_unit.sv */
`include "pipe_macros.svh"

module hazard_unit (
	input logic id_rs1_rena,
	input logic [`REG_AW-1:0] id_rs1_addr,
	input logic id_rs2_rena,
	input logic [`REG_AW-1:0] id_rs2_addr,
	input pipe_pkg::ex_hazard_t ex_info,
	output pipe_pkg::pipe_stall_t stall
);
	import pipe_pkg::*;

	logic rs1_hit;
	logic rs2_hit;
	logic load_use;

	assign rs1_hit = id_rs1_rena && (id_rs1_addr == ex_info.rd_ex);
	assign rs2_hit = id_rs2_rena && (id_rs2_addr == ex_info.rd_ex);
	assign load_use = ex_info.load_in_ex && (ex_info.rd_ex != '0) && (rs1_hit || rs2_hit);

	always_comb begin
		if (ex_info.transfer) begin
			// the two younger instructions are on the wrong path.
			stall.pc = STALL_NEXT;
			stall.if_id = STALL_ZERO;
			stall.id_ex = STALL_ZERO;
			stall.ex_me = STALL_ZERO;
			stall.me_wb = STALL_NEXT;
		end else if (ex_info.mul_req) begin
			stall.pc = STALL_KEEP;
			stall.if_id = STALL_KEEP;
			stall.id_ex = STALL_KEEP;
			stall.ex_me = STALL_ZERO;
			stall.me_wb = STALL_NEXT;
		end else if (load_use) begin
			// the load moves on to memory while its consumer waits one cycle in decode.
			stall.pc = STALL_KEEP;
			stall.if_id = STALL_KEEP;
			stall.id_ex = STALL_ZERO;
			stall.ex_me = STALL_NEXT;
			stall.me_wb = STALL_NEXT;
		end else begin
			stall.pc = STALL_NEXT;
			stall.if_id = STALL_NEXT;
			stall.id_ex = STALL_NEXT;
			stall.ex_me = STALL_NEXT;
			stall.me_wb = STALL_NEXT;
		end
	end

endmodule

/* hdl/mem_arbiter.sv */
module mem_arbiter (
	input logic clk,
	input logic rst_n,
	input pipe_pkg::mem_req_t fetch_req,
	input pipe_pkg::mem_req_t data_req,
	output logic fetch_gnt,
	output pipe_pkg::mem_req_t bus_req
);

	// the data port is older in program order, so it always goes first.
	assign fetch_gnt = fetch_req.valid && !data_req.valid;
	assign bus_req = data_req.valid ? data_req : fetch_req;

	assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req.valid |-> !fetch_req.we)
		else $error("mem_arbiter: fetch request marked as write");

endmodule

/* core/fetch_stage.sv */
`include "pipe_macros.svh"

module fetch_stage (
	input logic clk,
	input logic rst_n,
	input pipe_pkg::stall_e stall_pc,
	input pipe_pkg::stall_e stall_if_id,
	input logic redirect,
	input logic [`XLEN-1:0] redirect_pc,
	output pipe_pkg::mem_req_t fetch_req,
	input logic fetch_gnt,
	input logic [`XLEN-1:0] mem_rdata,
	output pipe_pkg::instr_u if_id_instr,
	output logic [`XLEN-1:0] if_id_pc,
	output logic if_id_valid
);
	import pipe_pkg::*;

	logic [`XLEN-1:0] pc;
	logic fetch_on;

	// fetching starts on the first cycle after reset is released.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_on <= 1'b0;
		end else begin
			fetch_on <= 1'b1;
		end
	end

	assign fetch_req.valid = fetch_on;
	assign fetch_req.we = 1'b0;
	assign fetch_req.addr = pc[`MEM_AW+1:2];
	assign fetch_req.wdata = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (stall_pc == STALL_NEXT && fetch_gnt) begin
			pc <= pc + `XLEN'(4);
		end
	end

	// a fetch that lost the bus leaves a bubble behind.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id_valid <= 1'b0;
			if_id_instr <= '0;
			if_id_pc <= '0;
		end else begin
			case (stall_if_id)
				STALL_NEXT: begin
					if_id_valid <= fetch_gnt;
					if_id_instr <= mem_rdata;
					if_id_pc <= pc;
				end
				STALL_ZERO: if_id_valid <= 1'b0;
				default: ;
			endcase
		end
	end

endmodule

/* core/decode_stage.sv */
`include "pipe_macros.svh"

module decode_stage (
	input logic clk,
	input logic rst_n,
	input pipe_pkg::instr_u if_id_instr,
	input logic [`XLEN-1:0] if_id_pc,
	input logic if_id_valid,
	input pipe_pkg::stall_e stall_id_ex,
	input pipe_pkg::retire_t wb,
	input pipe_pkg::ex_me_t ex_fwd,
	input pipe_pkg::ex_me_t me_fwd,
	output logic rs1_rena,
	output logic [`REG_AW-1:0] rs1_addr,
	output logic rs2_rena,
	output logic [`REG_AW-1:0] rs2_addr,
	output pipe_pkg::id_ex_t id_ex
);
	import pipe_pkg::*;

	localparam logic [6:0] OPC_IMM = 7'b0010011;
	localparam logic [6:0] OPC_REG = 7'b0110011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	logic [`XLEN-1:0] regs [0:(1 << `REG_AW)-1];
	op_e op;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic writes_rd;
	id_ex_t id_ex_next;

	// the nearest producer wins, in the order execute, memory, writeback, register file.
	function automatic logic [`XLEN-1:0] src_value(input logic [`REG_AW-1:0] addr);
		logic [`XLEN-1:0] value;
		if (addr == '0)
			value = '0;
		else if (ex_fwd.valid && ex_fwd.we && ex_fwd.rd == addr)
			value = ex_fwd.result;
		else if (me_fwd.valid && me_fwd.we && me_fwd.rd == addr)
			value = me_fwd.result;
		else if (wb.valid && wb.rd == addr)
			value = wb.data;
		else
			value = regs[addr];
		return value;
	endfunction

	always_comb begin
		op = OP_NOP;
		if (if_id_valid) begin
			case (if_id_instr.r.opcode)
				OPC_IMM: if (if_id_instr.i.funct3 == 3'b000) op = OP_ADDI;
				OPC_LOAD: if (if_id_instr.i.funct3 == 3'b010) op = OP_LW;
				OPC_STORE: if (if_id_instr.r.funct3 == 3'b010) op = OP_SW;
				OPC_BRANCH: if (if_id_instr.r.funct3 == 3'b000) op = OP_BEQ;
				OPC_REG: begin
					if (if_id_instr.r.funct3 == 3'b000 && if_id_instr.r.funct7 == 7'b0000000)
						op = OP_ADD;
					else if (if_id_instr.r.funct3 == 3'b000 && if_id_instr.r.funct7 == 7'b0000001)
						op = OP_MUL;
				end
				default: ;
			endcase
		end
	end

	// S and B immediates are spread over the funct7 and rd fields.
	always_comb begin
		imm = '0;
		rs1_rena = 1'b0;
		rs2_rena = 1'b0;
		case (op)
			OP_ADDI, OP_LW: begin
				imm = {{(`XLEN-12){if_id_instr.i.imm12[11]}}, if_id_instr.i.imm12};
				rs1_rena = 1'b1;
			end
			OP_SW: begin
				imm = {{(`XLEN-12){if_id_instr.r.funct7[6]}}, if_id_instr.r.funct7,
					if_id_instr.r.rd};
				rs1_rena = 1'b1;
				rs2_rena = 1'b1;
			end
			OP_BEQ: begin
				imm = {{(`XLEN-13){if_id_instr.r.funct7[6]}}, if_id_instr.r.funct7[6],
					if_id_instr.r.rd[0], if_id_instr.r.funct7[5:0], if_id_instr.r.rd[4:1], 1'b0};
				rs1_rena = 1'b1;
				rs2_rena = 1'b1;
			end
			OP_ADD, OP_MUL: begin
				rs1_rena = 1'b1;
				rs2_rena = 1'b1;
			end
			default: ;
		endcase
	end

	assign rs1_addr = if_id_instr.r.rs1;
	assign rs2_addr = if_id_instr.r.rs2;
	assign writes_rd = (op == OP_ADDI) || (op == OP_ADD) || (op == OP_MUL) || (op == OP_LW);

	always_comb begin
		rs1_val = src_value(rs1_addr);
		rs2_val = src_value(rs2_addr);
	end

	always_comb begin
		id_ex_next.valid = (op != OP_NOP);
		id_ex_next.op = op;
		id_ex_next.rd = writes_rd ? if_id_instr.r.rd : '0;
		id_ex_next.rs1_en = rs1_rena;
		id_ex_next.rs1 = rs1_addr;
		id_ex_next.rs2_en = rs2_rena;
		id_ex_next.rs2 = rs2_addr;
		id_ex_next.opa = rs1_val;
		id_ex_next.opb = (op == OP_ADD || op == OP_MUL || op == OP_BEQ) ? rs2_val : imm;
		id_ex_next.store_data = rs2_val;
		id_ex_next.imm = imm;
		id_ex_next.pc = if_id_pc;
	end

	always_ff @(posedge clk) begin
		if (wb.valid && wb.rd != '0)
			regs[wb.rd] <= wb.data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else begin
			case (stall_id_ex)
				STALL_NEXT: id_ex <= id_ex_next;
				STALL_ZERO: id_ex <= '0;
				default: ;
			endcase
		end
	end

endmodule

/* core/execute_stage.sv */
`include "pipe_macros.svh"

module execute_stage (
	input logic clk,
	input logic rst_n,
	input pipe_pkg::id_ex_t id_ex,
	input pipe_pkg::stall_e stall_ex_me,
	output pipe_pkg::ex_hazard_t ex_info,
	output pipe_pkg::ex_me_t ex_fwd,
	output pipe_pkg::ex_me_t ex_me
);
	import pipe_pkg::*;

	localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

	logic [CNT_W-1:0] mul_cnt;
	logic is_mul;
	logic mul_req;
	logic [`XLEN-1:0] result;

	// mul_cnt is the execute cycle the MUL is in, starting at one.
	assign is_mul = id_ex.valid && (id_ex.op == OP_MUL);
	assign mul_req = is_mul && (mul_cnt != CNT_W'(`MUL_CYCLES));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mul_cnt <= CNT_W'(1);
		end else if (mul_req) begin
			mul_cnt <= mul_cnt + CNT_W'(1);
		end else begin
			mul_cnt <= CNT_W'(1);
		end
	end

	// ADDI, LW and SW arrive with the immediate already in operand b.
	always_comb begin
		if (id_ex.op == OP_MUL)
			result = id_ex.opa * id_ex.opb;
		else
			result = id_ex.opa + id_ex.opb;
	end

	always_comb begin
		ex_fwd.valid = id_ex.valid;
		ex_fwd.op = id_ex.op;
		ex_fwd.rd = id_ex.rd;
		ex_fwd.we = id_ex.valid && (id_ex.rd != '0);
		ex_fwd.result = result;
		ex_fwd.store_data = id_ex.store_data;
	end

	assign ex_info.load_in_ex = id_ex.valid && (id_ex.op == OP_LW);
	assign ex_info.rd_ex = id_ex.rd;
	assign ex_info.rd_me = ex_me.we ? ex_me.rd : '0;
	assign ex_info.transfer = id_ex.valid && (id_ex.op == OP_BEQ) && (id_ex.opa == id_ex.opb);
	assign ex_info.target = id_ex.pc + id_ex.imm;
	assign ex_info.mul_req = mul_req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_me <= '0;
		end else begin
			case (stall_ex_me)
				STALL_NEXT: ex_me <= ex_fwd;
				STALL_ZERO: ex_me <= '0;
				default: ;
			endcase
		end
	end

	// every stall cycle of a MUL keeps it in execute and sends a bubble on.
	assert property (@(posedge clk) disable iff (!rst_n)
		mul_req |=> $stable(id_ex) && !ex_me.valid)
		else $error("execute_stage: MUL left execute during its stall");

endmodule

/* core/mem_wb_stage.sv */
`include "pipe_macros.svh"

module mem_wb_stage (
	input logic clk,
	input logic rst_n,
	input pipe_pkg::ex_me_t ex_me,
	input pipe_pkg::stall_e stall_me_wb,
	output pipe_pkg::mem_req_t data_req,
	input logic [`XLEN-1:0] mem_rdata,
	output pipe_pkg::ex_me_t me_fwd,
	output pipe_pkg::retire_t retire
);
	import pipe_pkg::*;

	logic is_load;
	logic is_store;

	assign is_load = ex_me.valid && (ex_me.op == OP_LW);
	assign is_store = ex_me.valid && (ex_me.op == OP_SW);

	assign data_req.valid = is_load || is_store;
	assign data_req.we = is_store;
	assign data_req.addr = ex_me.result[`MEM_AW+1:2];
	assign data_req.wdata = ex_me.store_data;

	// load data returns in the same cycle, so decode can take it directly.
	always_comb begin
		me_fwd = ex_me;
		if (is_load)
			me_fwd.result = mem_rdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire <= '0;
		end else begin
			case (stall_me_wb)
				STALL_NEXT: begin
					retire.valid <= me_fwd.valid && me_fwd.we;
					retire.rd <= me_fwd.rd;
					retire.data <= me_fwd.result;
				end
				STALL_ZERO: retire <= '0;
				default: ;
			endcase
		end
	end

endmodule

/* core/pipe_top.sv */
`include "pipe_macros.svh"

module pipe_top (
	input logic clk,
	input logic rst_n,
	output pipe_pkg::mem_req_t bus_req,
	input logic [`XLEN-1:0] mem_rdata,
	output pipe_pkg::retire_t retire
);
	import pipe_pkg::*;

	pipe_stall_t stall;
	mem_req_t fetch_req;
	mem_req_t data_req;
	logic fetch_gnt;
	instr_u if_id_instr;
	logic [`XLEN-1:0] if_id_pc;
	logic if_id_valid;
	logic rs1_rena;
	logic [`REG_AW-1:0] rs1_addr;
	logic rs2_rena;
	logic [`REG_AW-1:0] rs2_addr;
	id_ex_t id_ex;
	ex_hazard_t ex_info;
	ex_me_t ex_fwd;
	ex_me_t ex_me;
	ex_me_t me_fwd;

	fetch_stage i_fetch_stage (
		.clk(clk),
		.rst_n(rst_n),
		.stall_pc(stall.pc),
		.stall_if_id(stall.if_id),
		.redirect(ex_info.transfer),
		.redirect_pc(ex_info.target),
		.fetch_req(fetch_req),
		.fetch_gnt(fetch_gnt),
		.mem_rdata(mem_rdata),
		.if_id_instr(if_id_instr),
		.if_id_pc(if_id_pc),
		.if_id_valid(if_id_valid)
	);

	decode_stage i_decode_stage (
		.clk(clk),
		.rst_n(rst_n),
		.if_id_instr(if_id_instr),
		.if_id_pc(if_id_pc),
		.if_id_valid(if_id_valid),
		.stall_id_ex(stall.id_ex),
		.wb(retire),
		.ex_fwd(ex_fwd),
		.me_fwd(me_fwd),
		.rs1_rena(rs1_rena),
		.rs1_addr(rs1_addr),
		.rs2_rena(rs2_rena),
		.rs2_addr(rs2_addr),
		.id_ex(id_ex)
	);

	execute_stage i_execute_stage (
		.clk(clk),
		.rst_n(rst_n),
		.id_ex(id_ex),
		.stall_ex_me(stall.ex_me),
		.ex_info(ex_info),
		.ex_fwd(ex_fwd),
		.ex_me(ex_me)
	);

	mem_wb_stage i_mem_wb_stage (
		.clk(clk),
		.rst_n(rst_n),
		.ex_me(ex_me),
		.stall_me_wb(stall.me_wb),
		.data_req(data_req),
		.mem_rdata(mem_rdata),
		.me_fwd(me_fwd),
		.retire(retire)
	);

	hazard_unit i_hazard_unit (
		.id_rs1_rena(rs1_rena),
		.id_rs1_addr(rs1_addr),
		.id_rs2_rena(rs2_rena),
		.id_rs2_addr(rs2_addr),
		.ex_info(ex_info),
		.stall(stall)
	);

	mem_arbiter i_mem_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.data_req(data_req),
		.fetch_gnt(fetch_gnt),
		.bus_req(bus_req)
	);

endmodule

/* tests/tb_pipe.sv */
`include "pipe_macros.svh"

module tb_pipe;
	import pipe_pkg::*;

	localparam int PROG_LEN = 48;
	localparam int LAST_WORD = PROG_LEN - 1;
	localparam int PROG_WORDS = 64;
	localparam int DATA_BASE = 128;
	localparam int DATA_WORDS = 64;
	localparam int MEM_WORDS = 1 << `MEM_AW;
	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 20;
	localparam int WATCHDOG_CYCLES = PROG_LEN * (`MUL_CYCLES + 3) + 100;

	logic clk;
	logic rst_n;
	mem_req_t bus_req;
	logic [`XLEN-1:0] mem_rdata;
	retire_t retire;

	logic [`XLEN-1:0] mem [0:MEM_WORDS-1];
	logic [`XLEN-1:0] model_mem [0:MEM_WORDS-1];
	op_e prog_op [0:PROG_LEN-1];
	logic [`REG_AW-1:0] prog_rd [0:PROG_LEN-1];
	logic [`REG_AW-1:0] prog_rs1 [0:PROG_LEN-1];
	logic [`REG_AW-1:0] prog_rs2 [0:PROG_LEN-1];
	logic [`XLEN-1:0] prog_imm [0:PROG_LEN-1];
	retire_t exp_retire [$];
	mem_req_t exp_write [$];
	integer seed;
	int retire_errors;
	int bus_errors;
	int other_errors;
	logic fetch_seen;

	pipe_top i_pipe_top (
		.clk(clk),
		.rst_n(rst_n),
		.bus_req(bus_req),
		.mem_rdata(mem_rdata),
		.retire(retire)
	);

	// the memory answers in the same cycle and takes writes at the clock edge.
	assign mem_rdata = mem[bus_req.addr];

	always @(posedge clk) begin
		if (bus_req.valid && bus_req.we)
			mem[bus_req.addr] <= bus_req.wdata;
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return r % n;
	endfunction

	// an odd multiplier keeps every address distinct.
	function automatic logic [`XLEN-1:0] fill_word(input logic [`MEM_AW-1:0] a);
		return (`XLEN'(a) * `XLEN'(32'h01000193)) ^ `XLEN'(32'h5a5a5a5a);
	endfunction

	function automatic logic [`XLEN-1:0] encode(input op_e op, input logic [`REG_AW-1:0] rd,
		input logic [`REG_AW-1:0] rs1, input logic [`REG_AW-1:0] rs2,
		input logic [`XLEN-1:0] imm);
		logic [11:0] i12;
		logic [12:0] b13;
		i12 = imm[11:0];
		b13 = imm[12:0];
		case (op)
			OP_ADDI: return {i12, rs1, 3'b000, rd, 7'b0010011};
			OP_LW: return {i12, rs1, 3'b010, rd, 7'b0000011};
			OP_ADD: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			OP_MUL: return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
			OP_SW: return {i12[11:5], rs2, rs1, 3'b010, i12[4:0], 7'b0100011};
			OP_BEQ: return {b13[12], b13[10:5], rs2, rs1, 3'b000, b13[4:1], b13[11],
				7'b1100011};
			default: return 32'h00000013;
		endcase
	endfunction

	// x1 to x7 get a value first, so nothing reads an unwritten register.
	task automatic build_program();
		int span;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[`MEM_AW'(i)] = fill_word(`MEM_AW'(i));
		for (int i = PROG_LEN; i < PROG_WORDS; i++)
			mem[`MEM_AW'(i)] = 32'h00000013;
		for (int i = 0; i < LAST_WORD; i++) begin
			prog_rd[i] = `REG_AW'(1 + rand_below(7));
			prog_rs1[i] = `REG_AW'(1 + rand_below(7));
			prog_rs2[i] = `REG_AW'(1 + rand_below(7));
			prog_imm[i] = `XLEN'(rand_below(4096) - 2048);
			if (i < 7) begin
				prog_op[i] = OP_ADDI;
				prog_rd[i] = `REG_AW'(i + 1);
				prog_rs1[i] = '0;
			end else begin
				case (rand_below(6))
					0: prog_op[i] = OP_ADDI;
					1: prog_op[i] = OP_ADD;
					2: prog_op[i] = OP_MUL;
					3: prog_op[i] = OP_LW;
					4: prog_op[i] = OP_SW;
					default: prog_op[i] = OP_BEQ;
				endcase
			end
			case (prog_op[i])
				OP_LW, OP_SW: begin
					prog_rs1[i] = '0;
					prog_imm[i] = `XLEN'((DATA_BASE + rand_below(DATA_WORDS)) * 4);
				end
				OP_BEQ: begin
					span = (LAST_WORD - i < 8) ? LAST_WORD - i : 8;
					if (rand_below(3) == 0)
						prog_rs2[i] = prog_rs1[i];
					prog_imm[i] = `XLEN'((1 + rand_below(span)) * 4);
				end
				default: ;
			endcase
		end
		// the last word branches to itself and parks the core.
		prog_op[LAST_WORD] = OP_BEQ;
		prog_rd[LAST_WORD] = '0;
		prog_rs1[LAST_WORD] = '0;
		prog_rs2[LAST_WORD] = '0;
		prog_imm[LAST_WORD] = '0;
		for (int i = 0; i < PROG_LEN; i++)
			mem[`MEM_AW'(i)] = encode(prog_op[i], prog_rd[i], prog_rs1[i], prog_rs2[i],
				prog_imm[i]);
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[`MEM_AW'(i)] = mem[`MEM_AW'(i)];
	endtask

	task automatic run_model();
		logic [`XLEN-1:0] regs [0:(1 << `REG_AW)-1];
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] sum;
		retire_t r;
		mem_req_t w;
		int pc;
		for (int k = 0; k < (1 << `REG_AW); k++)
			regs[k] = '0;
		pc = 0;
		while (pc < LAST_WORD) begin
			a = regs[prog_rs1[pc]];
			b = regs[prog_rs2[pc]];
			sum = a + prog_imm[pc];
			r.valid = 1'b1;
			r.rd = prog_rd[pc];
			r.data = sum;
			w.valid = 1'b1;
			w.we = 1'b1;
			w.addr = sum[`MEM_AW+1:2];
			w.wdata = b;
			case (prog_op[pc])
				OP_ADD: r.data = a + b;
				OP_MUL: r.data = a * b;
				OP_LW: r.data = model_mem[sum[`MEM_AW+1:2]];
				OP_SW: begin
					model_mem[sum[`MEM_AW+1:2]] = b;
					exp_write.push_back(w);
				end
				default: ;
			endcase
			if (prog_op[pc] inside {OP_ADDI, OP_ADD, OP_MUL, OP_LW} && r.rd != '0) begin
				regs[r.rd] = r.data;
				exp_retire.push_back(r);
			end
			if (prog_op[pc] == OP_BEQ && a == b)
				pc = pc + int'(prog_imm[pc] >> 2);
			else
				pc = pc + 1;
		end
	endtask

	task automatic compare_retire(input retire_t expected, input retire_t actual);
		if (actual !== expected) begin
			retire_errors++;
			$display("mismatch at time %0t on retire: expected x%0d %h, got x%0d %h",
				$time, expected.rd, expected.data, actual.rd, actual.data);
		end
	endtask

	// values are shown as write enable, word address and data.
	task automatic compare_bus(input mem_req_t expected, input mem_req_t actual,
		input string name);
		if (actual !== expected) begin
			bus_errors++;
			$display("mismatch at time %0t on %s: expected %b/%h/%h, got %b/%h/%h",
				$time, name, expected.we, expected.addr, expected.wdata,
				actual.we, actual.addr, actual.wdata);
		end
	endtask

	task automatic print_error_counts();
		$display("errors: retire %0d, bus %0d, other %0d", retire_errors, bus_errors,
			other_errors);
	endtask

	// outputs settle well before the falling edge, so they are checked there.
	always @(negedge clk) begin
		mem_req_t first_fetch;
		first_fetch = '0;
		first_fetch.valid = 1'b1;
		if (!fetch_seen) begin
			if (retire.valid) begin
				other_errors++;
				$display("retire valid at time %0t before the first fetch", $time);
			end
			if (bus_req.valid) begin
				fetch_seen = 1'b1;
				compare_bus(first_fetch, bus_req, "first bus_req");
			end
		end else begin
			if (retire.valid) begin
				if (exp_retire.size() == 0) begin
					other_errors++;
					$display("unexpected retire of x%0d at time %0t", retire.rd, $time);
				end else begin
					compare_retire(exp_retire.pop_front(), retire);
				end
			end
			if (bus_req.valid && bus_req.we) begin
				if (exp_write.size() == 0) begin
					other_errors++;
					$display("unexpected bus write to word %h at time %0t", bus_req.addr, $time);
				end else begin
					compare_bus(exp_write.pop_front(), bus_req, "bus_req");
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		seed = 25301;
		retire_errors = 0;
		bus_errors = 0;
		other_errors = 0;
		fetch_seen = 1'b0;
		build_program();
		run_model();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		while (exp_retire.size() != 0 || exp_write.size() != 0)
			@(posedge clk);
		// stray retires or writes after the last expected one still get caught.
		repeat (DRAIN_CYCLES) @(posedge clk);
		print_error_counts();
		if (retire_errors + bus_errors + other_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + DRAIN_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout with %0d retires and %0d bus writes still expected",
			exp_retire.size(), exp_write.size());
		print_error_counts();
		$display("sim failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+common
common/pipe_pkg.sv
hdl/hazard_unit.sv
hdl/mem_arbiter.sv
core/fetch_stage.sv
core/decode_stage.sv
core/execute_stage.sv
core/mem_wb_stage.sv
core/pipe_top.sv
tests/tb_pipe.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_pipe
FILELIST = filelist.f
BUILD_DIR = obj_dir
SIM_BIN = $(BUILD_DIR)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
